// ==== Bender.yml ====
package:
  name: dma_controller

sources:
  - files:
      - verilog/dma_pkg.sv
      - verilog/dma_io_regs.sv
      - verilog/oam_dma_engine.sv
      - verilog/gdma_engine.sv
      - verilog/dma_port_arbiter.sv
      - verilog/dma_controller.sv
  - target: test
    files:
      - testbench/dma_mem_model.sv
      - testbench/dma_tb.sv

// ==== sim.f ====
verilog/dma_pkg.sv
verilog/dma_io_regs.sv
verilog/oam_dma_engine.sv
verilog/gdma_engine.sv
verilog/dma_port_arbiter.sv
verilog/dma_controller.sv
testbench/dma_mem_model.sv
testbench/dma_tb.sv

// ==== testbench/dma_mem_model.sv ====
module dma_mem_model (
   input  logic              I_CLK,
   input  logic              rand_en,
   input  dma_pkg::dma_req_t req,
   input  logic [7:0]        wr_data,
   output logic [7:0]        rd_data,
   output logic              ready
);

   logic [7:0] mem [0:65535];

   // every byte is a hash of its full address
   task automatic fill();
      for (int a = 0; a < 65536; a++) begin
         mem[a] = 8'(a) ^ (8'(a >> 8) * 8'd13) ^ 8'h5A;
      end
   endtask

   assign rd_data = mem[req.rd_addr]; // combinational read

   always @(posedge I_CLK) begin
      if (req.valid && ready) begin
         mem[req.wr_addr] <= wr_data;
      end
   end

   // ready changes a short time after each rising edge
   initial begin
      void'($urandom(55857));
      ready = 1'b1;
      forever begin
         @(posedge I_CLK);
         #10;
         ready = rand_en ? 1'($urandom) : 1'b1;
      end
   end

endmodule

// ==== testbench/dma_tb.sv ====
module dma_tb;
   import dma_pkg::*;

   localparam int TIMEOUT_CYCLES = 4000;

   logic        I_CLK;
   logic        I_SYNC_RESET;
   logic [15:0] io_addr;
   logic [7:0]  io_wdata;
   logic        io_we;
   logic        io_re;
   logic [7:0]  io_rdata;
   dma_req_t    mem_req;
   logic        mem_ready;
   logic [7:0]  rd_data;
   logic [7:0]  wr_data;
   logic        rand_en;

   logic [7:0]  ref_mem [0:65535];
   logic [15:0] wr_log [$];   // destination of every accepted byte, in order
   logic [7:0]  hvals [4] = '{8'h34, 8'h5B, 8'hE9, 8'h27}; // HDMA1-4, dirty low and high bits
   logic        oam_on = 1'b0;
   logic [15:0] gdma_lo = 16'hFFFF; // empty window
   logic [15:0] gdma_hi = 16'h0000;
   logic [15:0] gdma_src;
   logic [15:0] gdma_dst;
   int          gdma_len;
   int          errors = 0;
   int          tests_run = 0;
   int          tests_failed = 0;
   int          cycles = 0;

   dma_controller dut (
      .I_CLK        (I_CLK),
      .I_SYNC_RESET (I_SYNC_RESET),
      .io_addr      (io_addr),
      .io_wdata     (io_wdata),
      .io_we        (io_we),
      .io_re        (io_re),
      .io_rdata     (io_rdata),
      .mem_req      (mem_req),
      .mem_ready    (mem_ready),
      .rd_data      (rd_data),
      .wr_data      (wr_data)
   );

   dma_mem_model u_mem (
      .I_CLK   (I_CLK),
      .rand_en (rand_en),
      .req     (mem_req),
      .wr_data (wr_data),
      .rd_data (rd_data),
      .ready   (mem_ready)
   );

   initial begin
      I_CLK = 1'b0;
      forever #50 I_CLK = ~I_CLK;
   end

   always @(posedge I_CLK) begin
      cycles++;
      if (cycles == TIMEOUT_CYCLES) begin
         $display("timeout: run hung, still going after %0d cycles", TIMEOUT_CYCLES);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   always @(negedge I_CLK) begin
      if (!I_SYNC_RESET && mem_req.valid && mem_ready) begin
         wr_log.push_back(mem_req.wr_addr); // this byte lands on the next edge
      end
   end

   function automatic bit dst_allowed(input logic [15:0] a);
      return (oam_on && a >= OAM_BASE && a < OAM_BASE + 16'(OAM_LEN))
         || (a >= gdma_lo && a <= gdma_hi);
   endfunction

   stable_under_stall: assert property (@(posedge I_CLK) disable iff (I_SYNC_RESET)
      (mem_req.valid && !mem_ready) |=> $stable(mem_req))
      else begin
         errors++;
         $display("mem_req changed while mem_ready was low, at %0t", $time);
      end

   write_in_window: assert property (@(posedge I_CLK) disable iff (I_SYNC_RESET)
      (mem_req.valid && mem_ready) |-> dst_allowed(mem_req.wr_addr))
      else begin
         errors++;
         $display("write to %h at %0t lies outside the active destination",
            $sampled(mem_req.wr_addr), $time);
      end

   task automatic check_val(input string name, input int exp, input int act);
      assert (act == exp) else begin
         errors++;
         $display("CHECK FAILED at %0t: %s expected %0h got %0h", $time, name, exp, act);
      end
   endtask

   task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
      @(posedge I_CLK);
      #10;
      io_addr  = addr;
      io_wdata = data;
      io_we    = 1'b1;
      @(posedge I_CLK); // register latches here
      #10;
      io_we = 1'b0;
   endtask

   task automatic io_read(input logic [15:0] addr, output logic [7:0] data);
      @(posedge I_CLK);
      #10;
      io_addr = addr;
      io_re   = 1'b1;
      #30;
      data  = io_rdata;
      io_re = 1'b0;
   endtask

   task automatic reload_mem();
      u_mem.fill();
      for (int a = 0; a < 65536; a++) begin
         ref_mem[a] = u_mem.mem[a];
      end
   endtask

   task automatic ref_copy(input logic [15:0] src, input logic [15:0] dst, input int len);
      for (int i = 0; i < len; i++) begin
         ref_mem[16'(dst + i)] = ref_mem[16'(src + i)];
      end
   endtask

   task automatic compare_mem();
      int shown;
      shown = 0;
      for (int a = 0; a < 65536; a++) begin
         assert (u_mem.mem[a] === ref_mem[a]) else begin
            errors++;
            if (shown < 8) begin
               $display("CHECK FAILED at %0t: mem[%h] expected %h got %h",
                  $time, 16'(a), ref_mem[a], u_mem.mem[a]);
            end
            shown++;
         end
      end
   endtask

   // counts the cycles the port is requested, from first valid to valid low
   task automatic wait_copy(output int busy_cycles);
      busy_cycles = 0;
      @(negedge I_CLK);
      while (!mem_req.valid) @(negedge I_CLK);
      while (mem_req.valid) begin
         busy_cycles++;
         @(negedge I_CLK);
      end
   endtask

   task automatic run_oam(input logic [7:0] page, input bit exact);
      int n;
      oam_on = 1'b1;
      io_write(DMA_ADDR, page);
      wait_copy(n);
      if (exact) begin
         check_val("oam valid cycles", 160, n);
      end
      ref_copy({page, 8'h00}, OAM_BASE, 160);
      oam_on = 1'b0;
   endtask

   task automatic start_gdma(input logic [6:0] blocks);
      gdma_src = {hvals[0], hvals[1] & 8'hF0};
      gdma_dst = VRAM_BASE | ({hvals[2], hvals[3]} & 16'h1FF0); // 13 bit offset, nibble clear
      gdma_len = (int'(blocks) + 1) * 16;
      for (int k = 0; k < 4; k++) begin
         io_write(HDMA1_ADDR + 16'(k), hvals[k]);
      end
      gdma_lo = gdma_dst;
      gdma_hi = gdma_dst + 16'(gdma_len - 1);
      io_write(HDMA5_ADDR, {1'b0, blocks});
   endtask

   task automatic finish_gdma();
      logic [7:0] v;
      ref_copy(gdma_src, gdma_dst, gdma_len);
      gdma_lo = 16'hFFFF;
      gdma_hi = 16'h0000;
      io_read(HDMA5_ADDR, v);
      check_val("HDMA5", 8'hFF, v);
   endtask

   task automatic run_gdma(input logic [6:0] blocks, input bit exact);
      int n;
      start_gdma(blocks);
      wait_copy(n);
      if (exact) begin
         check_val("gdma valid cycles", gdma_len, n);
      end
      finish_gdma();
   endtask

   task automatic end_test(input string name, input int errs_before);
      tests_run++;
      if (errors == errs_before) begin
         $display("test %-20s ok", name);
      end else begin
         tests_failed++;
         $display("test %-20s failed with %0d errors", name, errors - errs_before);
      end
   endtask

   initial begin
      int         e0;
      int         busy_reads;
      int         gdma_seen;
      int         oam_seen;
      logic [7:0] v;
      logic [7:0] prev;
      logic [7:0] fea0;
      I_SYNC_RESET = 1'b1;
      io_addr      = 16'h0000;
      io_wdata     = 8'h00;
      io_we        = 1'b0;
      io_re        = 1'b0;
      rand_en      = 1'b0;
      reload_mem();
      repeat (5) @(posedge I_CLK);
      #10;
      I_SYNC_RESET = 1'b0;

      e0 = errors;
      io_read(DMA_ADDR, v);
      check_val("DMA", 8'h00, v);
      for (int k = 0; k < 4; k++) begin
         io_read(HDMA1_ADDR + 16'(k), v);
         check_val($sformatf("HDMA%0d", k + 1), 8'h00, v);
      end
      io_read(HDMA5_ADDR, v);
      check_val("HDMA5", 8'hFF, v);
      for (int k = 0; k < 4; k++) begin
         io_write(HDMA1_ADDR + 16'(k), hvals[k]);
         io_read(HDMA1_ADDR + 16'(k), v);
         check_val($sformatf("HDMA%0d", k + 1), hvals[k], v);
      end
      end_test("register readback", e0);

      e0 = errors;
      fea0 = u_mem.mem[16'hFEA0];
      run_oam(8'h12, 1'b1);
      compare_mem();
      check_val("mem[FEA0]", fea0, u_mem.mem[16'hFEA0]);
      io_read(DMA_ADDR, v);
      check_val("DMA", 8'h12, v);
      end_test("oam copy", e0);

      e0 = errors;
      run_gdma(7'd2, 1'b1);
      io_write(HDMA5_ADDR, 8'h83); // hblank request, must do nothing
      repeat (5) begin
         @(negedge I_CLK);
         check_val("mem_req.valid", 0, mem_req.valid);
      end
      io_read(HDMA5_ADDR, v);
      check_val("HDMA5", 8'hFF, v);
      compare_mem();
      end_test("general dma", e0);

      e0 = errors;
      reload_mem();
      rand_en = 1'b1;
      run_oam(8'h12, 1'b0);
      run_gdma(7'd2, 1'b0);
      rand_en = 1'b0;
      compare_mem();
      end_test("back-pressure", e0);

      e0 = errors;
      reload_mem();
      wr_log.delete();
      start_gdma(7'd5);
      while (wr_log.size() < 20) @(negedge I_CLK); // inside the second block
      oam_on = 1'b1;
      io_write(DMA_ADDR, 8'h12);
      prev = 8'h7F;
      busy_reads = 0;
      do begin
         io_read(HDMA5_ADDR, v);
         if (v != 8'hFF) begin
            busy_reads++;
            check_val("HDMA5[7]", 0, v[7]);
            assert (v[6:0] <= prev[6:0]) else begin
               errors++;
               $display("CHECK FAILED at %0t: HDMA5 remaining expected <= %0h got %0h",
                  $time, prev[6:0], v[6:0]);
            end
            prev = v;
         end
      end while (v != 8'hFF);
      assert (busy_reads > 0) else begin
         errors++;
         $display("HDMA5 never showed a busy copy");
      end
      while (mem_req.valid) @(negedge I_CLK);
      ref_copy(16'h1200, OAM_BASE, 160);
      oam_on = 1'b0;
      finish_gdma();
      compare_mem();
      gdma_seen = 0;
      oam_seen = 0;
      foreach (wr_log[k]) begin
         if (wr_log[k] >= OAM_BASE) begin
            assert (gdma_seen % 16 == 0) else begin
               errors++;
               $display("oam write to %h split gdma block %0d", wr_log[k], gdma_seen / 16);
            end
            check_val("oam wr_addr", OAM_BASE + oam_seen, wr_log[k]);
            oam_seen++;
         end else begin
            check_val("gdma wr_addr", gdma_dst + gdma_seen, wr_log[k]);
            gdma_seen++;
         end
      end
      check_val("gdma writes", gdma_len, gdma_seen);
      check_val("oam writes", 160, oam_seen);
      end_test("priority and status", e0);

      $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
      if (errors == 0 && tests_failed == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== verilog/dma_controller.sv ====
module dma_controller (
   input  logic              I_CLK,
   input  logic              I_SYNC_RESET,
   input  logic [15:0]       io_addr,
   input  logic [7:0]        io_wdata,
   input  logic              io_we,
   input  logic              io_re,
   output logic [7:0]        io_rdata,
   output dma_pkg::dma_req_t mem_req,
   input  logic              mem_ready,
   input  logic [7:0]        rd_data,
   output logic [7:0]        wr_data
);
   import dma_pkg::*;

   logic         oam_start;
   logic [7:0]   oam_src_high;
   logic         gdma_start;
   hdma_cfg_t    hdma_cfg;
   gdma_status_t gdma_status;
   dma_req_t     oam_req;
   dma_req_t     gdma_req;
   logic         oam_ready;
   logic         gdma_ready;
   logic         gdma_block_end;

   // memory reads are combinational, so the byte goes straight back out
   assign wr_data = rd_data;

   dma_io_regs u_io_regs (
      .I_CLK        (I_CLK),
      .I_SYNC_RESET (I_SYNC_RESET),
      .io_addr      (io_addr),
      .io_wdata     (io_wdata),
      .io_we        (io_we),
      .io_re        (io_re),
      .io_rdata     (io_rdata),
      .status       (gdma_status),
      .oam_start    (oam_start),
      .oam_src_high (oam_src_high),
      .gdma_start   (gdma_start),
      .cfg          (hdma_cfg)
   );

   oam_dma_engine u_oam (
      .I_CLK        (I_CLK),
      .I_SYNC_RESET (I_SYNC_RESET),
      .start        (oam_start),
      .src_high     (oam_src_high),
      .req          (oam_req),
      .ready        (oam_ready)
   );

   gdma_engine u_gdma (
      .I_CLK        (I_CLK),
      .I_SYNC_RESET (I_SYNC_RESET),
      .start        (gdma_start),
      .cfg          (hdma_cfg),
      .req          (gdma_req),
      .ready        (gdma_ready),
      .block_end    (gdma_block_end),
      .status       (gdma_status)
   );

   dma_port_arbiter u_arb (
      .I_CLK          (I_CLK),
      .I_SYNC_RESET   (I_SYNC_RESET),
      .oam_req        (oam_req),
      .gdma_req       (gdma_req),
      .gdma_block_end (gdma_block_end),
      .oam_ready      (oam_ready),
      .gdma_ready     (gdma_ready),
      .mem_req        (mem_req),
      .mem_ready      (mem_ready)
   );

endmodule

// ==== verilog/dma_io_regs.sv ====
module dma_io_regs (
   input  logic                  I_CLK,
   input  logic                  I_SYNC_RESET,
   input  logic [15:0]           io_addr,
   input  logic [7:0]            io_wdata,
   input  logic                  io_we,
   input  logic                  io_re,
   output logic [7:0]            io_rdata,
   input  dma_pkg::gdma_status_t status,
   output logic                  oam_start,
   output logic [7:0]            oam_src_high,
   output logic                  gdma_start,
   output dma_pkg::hdma_cfg_t    cfg
);
   import dma_pkg::*;

   logic [7:0] dma_reg;
   logic [7:0] hdma1_reg;
   logic [7:0] hdma2_reg;
   logic [7:0] hdma3_reg;
   logic [7:0] hdma4_reg;
   logic [7:0] hdma5_reg; // configuration side only, never read back
   logic [7:0] hdma5_rd;

   always_ff @(posedge I_CLK) begin
      if (I_SYNC_RESET) begin
         dma_reg    <= 8'h00;
         hdma1_reg  <= 8'h00;
         hdma2_reg  <= 8'h00;
         hdma3_reg  <= 8'h00;
         hdma4_reg  <= 8'h00;
         hdma5_reg  <= 8'h00;
         oam_start  <= 1'b0;
         gdma_start <= 1'b0;
      end else begin
         oam_start  <= io_we && (io_addr == DMA_ADDR);
         gdma_start <= io_we && (io_addr == HDMA5_ADDR) && !io_wdata[7]; // hblank mode not started
         if (io_we) begin
            case (io_addr)
               DMA_ADDR:   dma_reg   <= io_wdata;
               HDMA1_ADDR: hdma1_reg <= io_wdata;
               HDMA2_ADDR: hdma2_reg <= io_wdata;
               HDMA3_ADDR: hdma3_reg <= io_wdata;
               HDMA4_ADDR: hdma4_reg <= io_wdata;
               HDMA5_ADDR: hdma5_reg <= io_wdata;
               default: ;
            endcase
         end
      end
   end

   // idle reads as FF, busy shows the remaining block count with bit 7 clear
   assign hdma5_rd = status.busy ? {1'b0, status.remaining} : 8'hFF;

   always_comb begin
      io_rdata = 8'h00;
      if (io_re) begin
         case (io_addr)
            DMA_ADDR:   io_rdata = dma_reg;
            HDMA1_ADDR: io_rdata = hdma1_reg;
            HDMA2_ADDR: io_rdata = hdma2_reg;
            HDMA3_ADDR: io_rdata = hdma3_reg;
            HDMA4_ADDR: io_rdata = hdma4_reg;
            HDMA5_ADDR: io_rdata = hdma5_rd;
            default:    io_rdata = 8'h00;
         endcase
      end
   end

   assign oam_src_high = dma_reg; // latched on the same edge as the start pulse

   assign cfg.src         = {hdma1_reg, hdma2_reg[7:4], 4'h0};
   assign cfg.dst_off     = {hdma3_reg[4:0], hdma4_reg[7:4], 4'h0}; // top bits dropped, stays in vram
   assign cfg.blocks      = hdma5_reg[6:0];
   assign cfg.hblank_mode = hdma5_reg[7];

endmodule

// ==== verilog/dma_pkg.sv ====
package dma_pkg;

   // io register map
   localparam logic [15:0] DMA_ADDR   = 16'hFF46;
   localparam logic [15:0] HDMA1_ADDR = 16'hFF51; // source high
   localparam logic [15:0] HDMA2_ADDR = 16'hFF52; // source low
   localparam logic [15:0] HDMA3_ADDR = 16'hFF53; // destination high
   localparam logic [15:0] HDMA4_ADDR = 16'hFF54; // destination low
   localparam logic [15:0] HDMA5_ADDR = 16'hFF55; // length/mode, status on read

   // sprite table copy
   localparam logic [15:0] OAM_BASE = 16'hFE00;
   localparam logic [7:0]  OAM_LEN  = 8'd160;

   // general purpose copy into video ram
   localparam logic [15:0] VRAM_BASE  = 16'h8000;
   localparam int          GDMA_BLOCK = 16; // bytes per block

   // one byte transfer on the shared memory port
   typedef struct packed {
      logic        valid;
      logic [15:0] rd_addr;
      logic [15:0] wr_addr;
   } dma_req_t;

   // general dma setup, already masked
   typedef struct packed {
      logic [15:0] src;         // low nibble cleared
      logic [12:0] dst_off;     // offset into vram, low nibble cleared
      logic [6:0]  blocks;      // block count minus one
      logic        hblank_mode;
   } hdma_cfg_t;

   // read back through HDMA5
   typedef struct packed {
      logic       busy;
      logic [6:0] remaining; // blocks left minus one
   } gdma_status_t;

endpackage

// ==== verilog/dma_port_arbiter.sv ====
module dma_port_arbiter (
   input  logic              I_CLK,
   input  logic              I_SYNC_RESET,
   input  dma_pkg::dma_req_t oam_req,
   input  dma_pkg::dma_req_t gdma_req,
   input  logic              gdma_block_end,
   output logic              oam_ready,
   output logic              gdma_ready,
   output dma_pkg::dma_req_t mem_req,
   input  logic              mem_ready
);
   import dma_pkg::*;

   localparam logic GNT_OAM  = 1'b0;
   localparam logic GNT_GDMA = 1'b1;

   logic grant_q;
   logic block_open; // gdma is inside a 16 byte block
   logic stall_q;    // last cycle's request was not taken, keep it on the port
   logic sel;
   logic gdma_accept;

   // re-arbitrate only between blocks and never under a pending request
   always_comb begin
      if (block_open || stall_q) begin
         sel = grant_q;
      end else begin
         sel = oam_req.valid ? GNT_OAM : GNT_GDMA;
      end
   end

   assign mem_req     = (sel == GNT_GDMA) ? gdma_req : oam_req;
   assign oam_ready   = mem_ready && (sel == GNT_OAM);
   assign gdma_ready  = mem_ready && (sel == GNT_GDMA);
   assign gdma_accept = gdma_req.valid && gdma_ready;

   always_ff @(posedge I_CLK) begin
      if (I_SYNC_RESET) begin
         grant_q    <= GNT_OAM;
         block_open <= 1'b0;
         stall_q    <= 1'b0;
      end else begin
         grant_q <= sel;
         stall_q <= mem_req.valid && !mem_ready;
         if (gdma_accept) begin
            block_open <= !gdma_block_end; // closes on the last byte of the block
         end
      end
   end

endmodule

// ==== verilog/gdma_engine.sv ====
module gdma_engine (
   input  logic                  I_CLK,
   input  logic                  I_SYNC_RESET,
   input  logic                  start,
   input  dma_pkg::hdma_cfg_t    cfg,
   output dma_pkg::dma_req_t     req,
   input  logic                  ready,
   output logic                  block_end,
   output dma_pkg::gdma_status_t status
);
   import dma_pkg::*;

   logic        busy;
   logic [3:0]  byte_cnt;     // byte within the current block
   logic [6:0]  remaining;    // blocks still to go after this one
   logic [6:0]  total_blocks;
   logic [6:0]  done_blocks;
   logic [15:0] src_base;
   logic [12:0] dst_base;
   logic [10:0] offset;
   logic [12:0] dst_cur;
   logic        launch;
   logic        accept;

   assign launch = start && !busy && !cfg.hblank_mode;
   assign accept = req.valid && ready;

   always_ff @(posedge I_CLK) begin
      if (I_SYNC_RESET) begin
         busy      <= 1'b0;
         byte_cnt  <= 4'd0;
         remaining <= 7'd0;
      end else if (launch) begin
         busy      <= 1'b1;
         byte_cnt  <= 4'd0;
         remaining <= cfg.blocks;
      end else if (accept) begin
         byte_cnt <= byte_cnt + 4'd1; // wraps to 0 at the block edge
         if (block_end) begin
            if (remaining == 7'd0) begin
               busy <= 1'b0;
            end else begin
               remaining <= remaining - 7'd1;
            end
         end
      end
   end

   // setup is captured once, later register writes do not disturb a running copy
   always_ff @(posedge I_CLK) begin
      if (launch) begin
         src_base     <= cfg.src;
         dst_base     <= cfg.dst_off;
         total_blocks <= cfg.blocks;
      end
   end

   assign done_blocks = total_blocks - remaining;
   assign offset      = {done_blocks, byte_cnt};
   assign dst_cur     = dst_base + {2'b00, offset}; // wraps inside the 8K window

   assign req.valid   = busy;
   assign req.rd_addr = src_base + {5'd0, offset};
   assign req.wr_addr = VRAM_BASE | {3'b000, dst_cur};

   assign block_end = busy && (byte_cnt == 4'(GDMA_BLOCK - 1));

   assign status.busy      = busy;
   assign status.remaining = remaining;

endmodule

// ==== verilog/oam_dma_engine.sv ====
module oam_dma_engine (
   input  logic              I_CLK,
   input  logic              I_SYNC_RESET,
   input  logic              start,
   input  logic [7:0]        src_high,
   output dma_pkg::dma_req_t req,
   input  logic              ready
);
   import dma_pkg::*;

   typedef enum logic {
      OAM_IDLE,
      OAM_RUN
   } oam_state_t;

   oam_state_t state;
   logic [7:0] count;    // byte index into the sprite table
   logic [7:0] src_page;
   logic       accept;

   assign accept = req.valid && ready;

   always_ff @(posedge I_CLK) begin
      if (I_SYNC_RESET) begin
         state <= OAM_IDLE;
         count <= 8'd0;
      end else begin
         case (state)
            OAM_IDLE: begin
               if (start) begin
                  state <= OAM_RUN;
                  count <= 8'd0;
               end
            end
            OAM_RUN: begin
               if (accept) begin // a new start is ignored here
                  if (count == OAM_LEN - 8'd1) begin
                     state <= OAM_IDLE;
                     count <= 8'd0;
                  end else begin
                     count <= count + 8'd1;
                  end
               end
            end
            default: state <= OAM_IDLE;
         endcase
      end
   end

   always_ff @(posedge I_CLK) begin
      if (state == OAM_IDLE && start) begin
         src_page <= src_high;
      end
   end

   assign req.valid   = (state == OAM_RUN);
   assign req.rd_addr = {src_page, count};
   assign req.wr_addr = OAM_BASE + {8'h00, count};

endmodule
